// ==== source/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

	typedef logic [31:0] cp0_word_t;
	typedef logic [4:0] cp0_addr_t;
	typedef logic [4:0] cp0_exc_t;

	// register numbers
	localparam cp0_addr_t REG_BADVADDR = 5'd8;
	localparam cp0_addr_t REG_COUNT = 5'd9;
	localparam cp0_addr_t REG_COMPARE = 5'd11;
	localparam cp0_addr_t REG_STATUS = 5'd12;
	localparam cp0_addr_t REG_CAUSE = 5'd13;
	localparam cp0_addr_t REG_EPC = 5'd14;
	localparam cp0_addr_t REG_PRID = 5'd15;
	localparam cp0_addr_t REG_CONFIG = 5'd16;

	typedef enum logic [1:0] {
		OP_MFC0 = 2'd0,
		OP_MTC0 = 2'd1,
		OP_EXC = 2'd2,
		OP_ERET = 2'd3
	} cp0_op_t;

	// ExcCode values
	localparam cp0_exc_t EXC_INT = 5'd0;
	localparam cp0_exc_t EXC_ADEL = 5'd4;
	localparam cp0_exc_t EXC_ADES = 5'd5;
	localparam cp0_exc_t EXC_SYS = 5'd8;
	localparam cp0_exc_t EXC_BP = 5'd9;
	localparam cp0_exc_t EXC_RI = 5'd10;
	localparam cp0_exc_t EXC_OV = 5'd12;
	localparam cp0_exc_t EXC_TR = 5'd13;

	localparam cp0_word_t STATUS_RESET = 32'h0040_0000; // BEV set
	localparam cp0_word_t CONFIG_RESET = 32'h0000_8000; // big endian
	localparam cp0_word_t PRID_RESET = 32'h004c_0102;

	localparam cp0_word_t EXC_VECTOR = 32'hbfc0_0380;

	// one decoded operation as it moves down the stages
	typedef struct packed {
		logic wen;
		cp0_addr_t waddr;
		cp0_addr_t raddr;
		cp0_word_t wdata;
		logic exc;
		cp0_exc_t code;
		cp0_word_t epc_val;
		logic bd;
		logic bad_en;
		cp0_word_t bad_addr;
		logic eret;
		logic rd;
	} cp0_action_t;

endpackage

`default_nettype wire

// ==== source/cp0_stage_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface cp0_stage_if;
	import cp0_pkg::*;

	logic valid;
	logic ready;
	cp0_action_t act;
	cp0_word_t rdata; // register value seen by the action

	modport src (
		output valid,
		output act,
		output rdata,
		input ready
	);

	modport dst (
		input valid,
		input act,
		input rdata,
		output ready
	);

endinterface

`default_nettype wire

// ==== source/cp0_cmd_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0_cmd_decode (
	input logic clk,
	input logic reset_i,
	input logic cmd_valid_i,
	output logic cmd_ready_o,
	input cp0_pkg::cp0_op_t cmd_op_i,
	input cp0_pkg::cp0_addr_t cmd_reg_i,
	input cp0_pkg::cp0_word_t cmd_data_i,
	input cp0_pkg::cp0_word_t cmd_pc_i,
	input logic cmd_bd_i,
	input cp0_pkg::cp0_word_t cmd_bad_addr_i,
	cp0_stage_if.src out
);
	import cp0_pkg::*;

	cp0_action_t next_act;
	cp0_exc_t code;
	logic read_only;
	logic take;

	// anything outside the known list is a reserved instruction
	function automatic cp0_exc_t legal_code(input cp0_exc_t c);
		case (c)
			EXC_INT, EXC_ADEL, EXC_ADES, EXC_SYS,
			EXC_BP, EXC_RI, EXC_OV, EXC_TR: legal_code = c;
			default: legal_code = EXC_RI;
		endcase
	endfunction

	assign cmd_ready_o = !out.valid || out.ready;
	assign take = cmd_valid_i && cmd_ready_o;
	assign code = legal_code(cmd_data_i[4:0]);
	assign read_only = (cmd_reg_i == REG_PRID) || (cmd_reg_i == REG_CONFIG) ||
		(cmd_reg_i == REG_BADVADDR);

	always_comb begin
		next_act = '0;
		next_act.waddr = cmd_reg_i;
		next_act.raddr = cmd_reg_i;
		next_act.wdata = cmd_data_i;
		next_act.bd = cmd_bd_i;
		next_act.bad_addr = cmd_bad_addr_i;
		next_act.epc_val = cmd_bd_i ? cmd_pc_i - 32'd4 : cmd_pc_i; // back to the branch
		case (cmd_op_i)
			OP_MFC0: next_act.rd = 1'b1;
			OP_MTC0: next_act.wen = !read_only;
			OP_EXC: begin
				next_act.exc = 1'b1;
				next_act.code = code;
				next_act.bad_en = (code == EXC_ADEL) || (code == EXC_ADES);
			end
			OP_ERET: next_act.eret = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			out.valid <= 1'b0;
		end else if (take) begin
			out.valid <= 1'b1;
		end else if (out.ready) begin
			out.valid <= 1'b0; // handed on with nothing behind it
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out.act <= next_act;
		end
	end

	assign out.rdata = '0; // no register read yet at this stage

endmodule

`default_nettype wire

// ==== source/cp0_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0_regs (
	input logic clk,
	input logic reset_i,
	input logic [5:0] int_i,
	cp0_stage_if.dst in,
	cp0_stage_if.src out,
	output logic timer_int_o,
	output logic int_pending_o
);
	import cp0_pkg::*;

	logic [32:0] count; // low bit halves the rate
	cp0_word_t count_w;
	cp0_word_t compare;
	cp0_word_t status;
	cp0_word_t cause;
	cp0_word_t epc;
	cp0_word_t badvaddr;
	cp0_word_t rd_word;
	logic take;

	assign count_w = count[32:1];
	assign in.ready = !out.valid || out.ready;
	assign take = in.valid && in.ready;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			count <= '0;
			compare <= '0;
			status <= STATUS_RESET;
			cause <= '0;
			epc <= '0;
			timer_int_o <= 1'b0;
		end else begin
			count <= count + 33'd1;
			cause[15:10] <= int_i; // hw interrupt lines
			if (compare != '0 && count_w == compare) begin
				timer_int_o <= 1'b1;
			end
			if (take && in.act.wen) begin
				case (in.act.waddr)
					REG_COUNT: begin
						count[32:1] <= in.act.wdata;
					end
					REG_COMPARE: begin
						compare <= in.act.wdata;
						timer_int_o <= 1'b0; // ack timer
					end
					REG_STATUS: begin
						status <= in.act.wdata;
					end
					REG_CAUSE: begin
						cause[9:8] <= in.act.wdata[9:8]; // sw interrupts
						cause[23] <= in.act.wdata[23];
						cause[22] <= in.act.wdata[22];
					end
					REG_EPC: begin
						epc <= in.act.wdata;
					end
					default: begin
					end
				endcase
			end
			if (take && in.act.exc) begin
				epc <= in.act.epc_val;
				cause[31] <= in.act.bd;
				cause[6:2] <= in.act.code;
				status[1] <= 1'b1; // EXL
			end
			if (take && in.act.eret) begin
				status[1] <= 1'b0;
			end
		end
	end

	// address faults only
	always_ff @(posedge clk) begin
		if (take && in.act.exc && in.act.bad_en) begin
			badvaddr <= in.act.bad_addr;
		end
	end

	always_comb begin
		case (in.act.raddr)
			REG_BADVADDR: rd_word = badvaddr;
			REG_COUNT: rd_word = count_w;
			REG_COMPARE: rd_word = compare;
			REG_STATUS: rd_word = status;
			REG_CAUSE: rd_word = cause;
			REG_EPC: rd_word = epc;
			REG_PRID: rd_word = PRID_RESET;
			REG_CONFIG: rd_word = CONFIG_RESET;
			default: rd_word = '0;
		endcase
		if (in.act.eret) begin
			rd_word = epc; // return target
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			out.valid <= 1'b0;
		end else if (take) begin
			out.valid <= 1'b1;
		end else if (out.ready) begin
			out.valid <= 1'b0;
		end
	end

	// value before the action lands
	always_ff @(posedge clk) begin
		if (take) begin
			out.act <= in.act;
			out.rdata <= rd_word;
		end
	end

	// IE set, EXL clear, some enabled line up
	assign int_pending_o = status[0] && !status[1] && |(cause[15:10] & status[15:10]);

endmodule

`default_nettype wire

// ==== source/cp0_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0_result (
	input logic clk,
	input logic reset_i,
	cp0_stage_if.dst in,
	output logic rsp_valid_o,
	input logic rsp_ready_i,
	output cp0_pkg::cp0_word_t rsp_data_o,
	output logic rsp_redirect_o,
	output cp0_pkg::cp0_word_t rsp_target_o
);
	import cp0_pkg::*;

	logic take;
	cp0_word_t target;

	assign in.ready = !rsp_valid_o || rsp_ready_i;
	assign take = in.valid && in.ready;

	always_comb begin
		if (in.act.exc) begin
			target = EXC_VECTOR;
		end else if (in.act.eret) begin
			target = in.rdata; // EPC came along as rdata
		end else begin
			target = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rsp_valid_o <= 1'b0;
			rsp_redirect_o <= 1'b0;
		end else if (take) begin
			rsp_valid_o <= 1'b1;
			rsp_redirect_o <= in.act.exc || in.act.eret;
		end else if (rsp_ready_i) begin
			rsp_valid_o <= 1'b0;
		end
	end

	// held while the consumer stalls
	always_ff @(posedge clk) begin
		if (take) begin
			rsp_data_o <= in.act.rd ? in.rdata : '0;
			rsp_target_o <= target;
		end
	end

endmodule

`default_nettype wire

// ==== source/cp0_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0_top (
	input logic clk,
	input logic reset_i,

	input logic cmd_valid_i,
	output logic cmd_ready_o,
	input cp0_pkg::cp0_op_t cmd_op_i,
	input cp0_pkg::cp0_addr_t cmd_reg_i,
	input cp0_pkg::cp0_word_t cmd_data_i, // wdata or exc code
	input cp0_pkg::cp0_word_t cmd_pc_i,
	input logic cmd_bd_i,
	input cp0_pkg::cp0_word_t cmd_bad_addr_i,

	output logic rsp_valid_o,
	input logic rsp_ready_i,
	output cp0_pkg::cp0_word_t rsp_data_o,
	output logic rsp_redirect_o,
	output cp0_pkg::cp0_word_t rsp_target_o,

	input logic [5:0] int_i,
	output logic timer_int_o,
	output logic int_pending_o
);

	cp0_stage_if dec_ex ();
	cp0_stage_if ex_res ();

	cp0_cmd_decode u_decode (
		.clk(clk),
		.reset_i(reset_i),
		.cmd_valid_i(cmd_valid_i),
		.cmd_ready_o(cmd_ready_o),
		.cmd_op_i(cmd_op_i),
		.cmd_reg_i(cmd_reg_i),
		.cmd_data_i(cmd_data_i),
		.cmd_pc_i(cmd_pc_i),
		.cmd_bd_i(cmd_bd_i),
		.cmd_bad_addr_i(cmd_bad_addr_i),
		.out(dec_ex.src)
	);

	cp0_regs u_regs (
		.clk(clk),
		.reset_i(reset_i),
		.int_i(int_i),
		.in(dec_ex.dst),
		.out(ex_res.src),
		.timer_int_o(timer_int_o),
		.int_pending_o(int_pending_o)
	);

	cp0_result u_result (
		.clk(clk),
		.reset_i(reset_i),
		.in(ex_res.dst),
		.rsp_valid_o(rsp_valid_o),
		.rsp_ready_i(rsp_ready_i),
		.rsp_data_o(rsp_data_o),
		.rsp_redirect_o(rsp_redirect_o),
		.rsp_target_o(rsp_target_o)
	);

endmodule

`default_nettype wire

// ==== testbench/cp0_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cp0_tb;
	import cp0_pkg::*;

	localparam int MAX_VEC = 64;
	localparam int COLS = 11; // words per vector line

	logic clk;
	logic reset_i;
	logic cmd_valid_i;
	logic cmd_ready_o;
	cp0_op_t cmd_op_i;
	cp0_addr_t cmd_reg_i;
	cp0_word_t cmd_data_i;
	cp0_word_t cmd_pc_i;
	logic cmd_bd_i;
	cp0_word_t cmd_bad_addr_i;
	logic rsp_valid_o;
	logic rsp_ready_i;
	cp0_word_t rsp_data_o;
	logic rsp_redirect_o;
	cp0_word_t rsp_target_o;
	logic [5:0] int_i;
	logic timer_int_o;
	logic int_pending_o;

	logic [31:0] vec_mem [0:MAX_VEC*COLS-1];
	int num_vec;
	int limit;
	int cycles;
	int done_cnt;
	int pending_q[$]; // oldest accepted command at the front
	integer seed = 32'h1230;

	cp0_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_mismatch(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_rsp(input cp0_word_t exp_data, input logic exp_redir,
			input cp0_word_t exp_target);
		if (rsp_data_o !== exp_data) begin
			report_mismatch($sformatf("rsp_data_o %h, expected %h", rsp_data_o, exp_data));
		end
		if (rsp_redirect_o !== exp_redir) begin
			report_mismatch($sformatf("rsp_redirect_o %b, expected %b", rsp_redirect_o,
				exp_redir));
		end
		if (rsp_target_o !== exp_target) begin
			report_mismatch($sformatf("rsp_target_o %h, expected %h", rsp_target_o,
				exp_target));
		end
	endtask

	task automatic check_line(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			report_mismatch($sformatf("%s is %b, expected %b", name, actual, expected));
		end
	endtask

	task automatic wait_timer_rise();
		int n;
		n = 0;
		while (!timer_int_o && n < 20) begin
			@(negedge clk);
			n++;
		end
		check_line("timer_int_o", timer_int_o, 1'b1);
	endtask

	task automatic check_lines(input int chk);
		case (chk)
			1: check_line("int_pending_o", int_pending_o, 1'b0);
			2: check_line("int_pending_o", int_pending_o, 1'b1);
			3: check_line("timer_int_o", timer_int_o, 1'b0);
			4: wait_timer_rise();
			default: ;
		endcase
	endtask

	// holds one command until the DUT takes it
	task automatic drive_cmd(input int idx);
		int base;
		logic accepted;
		base = idx * COLS;
		#1;
		cmd_valid_i = 1'b1;
		cmd_op_i = cp0_op_t'(vec_mem[base][1:0]);
		cmd_reg_i = vec_mem[base + 1][4:0];
		cmd_data_i = vec_mem[base + 2];
		cmd_pc_i = vec_mem[base + 3];
		cmd_bd_i = vec_mem[base + 4][0];
		cmd_bad_addr_i = vec_mem[base + 5];
		int_i = vec_mem[base + 6][5:0];
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = cmd_ready_o;
			@(posedge clk);
		end
		pending_q.push_back(idx);
		if (vec_mem[base + 10] != 0) begin
			#1 cmd_valid_i = 1'b0; // drain before a line check
			while (done_cnt <= idx) @(posedge clk);
		end
	endtask

	initial begin : ready_gen
		logic [31:0] rnd;
		rsp_ready_i = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			rnd = $random(seed);
			rsp_ready_i = rnd[0];
		end
	end

	initial begin : monitor
		int idx;
		int base;
		forever begin
			@(negedge clk);
			if (!reset_i && rsp_valid_o && rsp_ready_i) begin
				if (pending_q.size() == 0) begin
					$display("a response came out with no command outstanding");
					$display("Test failed");
					$fatal(1);
				end
				idx = pending_q.pop_front();
				base = idx * COLS;
				check_rsp(vec_mem[base + 7], vec_mem[base + 8][0], vec_mem[base + 9]);
				check_lines(int'(vec_mem[base + 10]));
				done_cnt++;
			end
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("timeout: responses never completed");
				$display("Test failed");
				$fatal(1);
			end
		end
	end

	initial begin
		reset_i = 1'b1;
		cmd_valid_i = 1'b0;
		cmd_op_i = OP_MFC0;
		cmd_reg_i = '0;
		cmd_data_i = '0;
		cmd_pc_i = '0;
		cmd_bd_i = 1'b0;
		cmd_bad_addr_i = '0;
		int_i = '0;
		done_cnt = 0;
		for (int i = 0; i < MAX_VEC * COLS; i++) begin
			vec_mem[i] = 32'hffff_0000 | i; // end marker in the op column
		end
		$readmemh("testbench/cp0_vectors.txt", vec_mem);
		num_vec = 0;
		while (num_vec < MAX_VEC &&
			vec_mem[num_vec * COLS] != (32'hffff_0000 | (num_vec * COLS))) begin
			num_vec++;
		end
		limit = 40 * num_vec + 200;
		if (num_vec == 0) begin
			$display("no vectors could be read from the vector file");
			$display("Test failed");
			$fatal(1);
		end
		repeat (10) @(posedge clk);
		#1 reset_i = 1'b0;
		@(negedge clk);
		check_line("cmd_ready_o", cmd_ready_o, 1'b1);
		check_line("rsp_valid_o", rsp_valid_o, 1'b0);
		check_line("rsp_redirect_o", rsp_redirect_o, 1'b0);
		check_line("timer_int_o", timer_int_o, 1'b0);
		check_line("int_pending_o", int_pending_o, 1'b0);
		@(posedge clk);
		for (int i = 0; i < num_vec; i++) begin
			drive_cmd(i);
		end
		#1 cmd_valid_i = 1'b0;
		while (done_cnt < num_vec) @(posedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
source/cp0_pkg.sv
source/cp0_stage_if.sv
source/cp0_cmd_decode.sv
source/cp0_regs.sv
source/cp0_result.sv
source/cp0_top.sv
testbench/cp0_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cp0 testbench with Verilator, run it, then look for the pass line
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps --top-module cp0_tb -f build.f -o cp0_sim
./obj_dir/cp0_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "Test completed successfully" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi

// ==== testbench/cp0_vectors.txt ====
// op reg data pc bd bad_addr int_i exp_data exp_redirect exp_target check
// check: 0 none, 1 int_pending low, 2 int_pending high, 3 timer low, 4 timer rises in 20
0 0c 00000000 00000000 0 00000000 00 00400000 0 00000000 0
0 0f 00000000 00000000 0 00000000 00 004c0102 0 00000000 0
0 10 00000000 00000000 0 00000000 00 00008000 0 00000000 0
0 03 00000000 00000000 0 00000000 00 00000000 0 00000000 0
1 0e 12345678 00000000 0 00000000 00 00000000 0 00000000 0
0 0e 00000000 00000000 0 00000000 00 12345678 0 00000000 0
1 0f ffffffff 00000000 0 00000000 00 00000000 0 00000000 0
0 0f 00000000 00000000 0 00000000 00 004c0102 0 00000000 0
1 0d ffffffff 00000000 0 00000000 00 00000000 0 00000000 0
0 0d 00000000 00000000 0 00000000 00 00c00300 0 00000000 0
2 00 00000008 80001000 0 00000000 00 00000000 1 bfc00380 0
0 0e 00000000 00000000 0 00000000 00 80001000 0 00000000 0
0 0d 00000000 00000000 0 00000000 00 00c00320 0 00000000 0
0 0c 00000000 00000000 0 00000000 00 00400002 0 00000000 0
3 00 00000000 00000000 0 00000000 00 00000000 1 80001000 0
0 0c 00000000 00000000 0 00000000 00 00400000 0 00000000 0
2 00 00000004 80002008 1 00000123 00 00000000 1 bfc00380 0
0 0e 00000000 00000000 0 00000000 00 80002004 0 00000000 0
0 0d 00000000 00000000 0 00000000 00 80c00310 0 00000000 0
0 08 00000000 00000000 0 00000000 00 00000123 0 00000000 0
0 0c 00000000 00000000 0 00000000 00 00400002 0 00000000 0
3 00 00000000 00000000 0 00000000 00 00000000 1 80002004 0
2 00 0000001f 80003000 0 00000000 00 00000000 1 bfc00380 0
0 0d 00000000 00000000 0 00000000 00 00c00328 0 00000000 0
1 0c 00000401 00000000 0 00000000 01 00000000 0 00000000 2
1 0c 00000001 00000000 0 00000000 01 00000000 0 00000000 1
0 0c 00000000 00000000 0 00000000 00 00000001 0 00000000 0
1 0b 00000003 00000000 0 00000000 00 00000000 0 00000000 0
0 0b 00000000 00000000 0 00000000 00 00000003 0 00000000 0
1 09 00000000 00000000 0 00000000 00 00000000 0 00000000 4
1 0b 00000000 00000000 0 00000000 00 00000000 0 00000000 3
